// File: rtl/cpuTypesPkg.sv
`default_nettype none

package cpuTypesPkg;

  // two cores share the memory system
  // snoop logic names the other core as ~owner, so this stays at 2
  localparam int CPUS = 2;

  // data word on load, store and ram lines
  typedef logic [31:0] wordT;

  // byte address, word index in bits 31:2
  typedef logic [31:0] addrT;

  // ram port status as seen by the controller
  typedef enum logic [1:0] {
    // no request on the port
    FREE,
    // request held, latency still counting
    BUSY,
    // request completes this cycle
    ACCESS,
    // address past the end of the ram
    ERROR
  } ramStateT;

endpackage

`default_nettype wire

// File: rtl/busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
  input  logic       CLK,
  input  logic       reset,
  input  logic [1:0] request,
  input  logic       done,
  output logic       grant
);

  // core that wins a tie
  logic priorityBit;
  // grant held for a core mid-transfer
  logic locked;
  logic lockedCore;

  always_comb begin
    if (locked && request[lockedCore]) begin
      // keep the current holder until its transfer ends
      grant = lockedCore;
    end else if (&request) begin
      grant = priorityBit;
    end else begin
      // single requester, or nobody (then core 0)
      grant = request[1];
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      priorityBit <= 1'b0;
      locked      <= 1'b0;
      lockedCore  <= 1'b0;
    end else if (done) begin
      // finished core yields the tie to the other one
      priorityBit <= ~grant;
      locked      <= 1'b0;
    end else if (|request) begin
      locked     <= 1'b1;
      lockedCore <= grant;
    end else begin
      locked <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/coherenceController.sv
`timescale 1ns/1ps
`default_nettype none

module coherenceController (
  input  logic                                          CLK,
  input  logic                                          reset,
  input  logic              [cpuTypesPkg::CPUS-1:0]     dREN,
  input  logic              [cpuTypesPkg::CPUS-1:0]     dWEN,
  input  cpuTypesPkg::addrT [cpuTypesPkg::CPUS-1:0]     daddr,
  input  cpuTypesPkg::wordT [cpuTypesPkg::CPUS-1:0]     dstore,
  input  logic              [cpuTypesPkg::CPUS-1:0]     ccwrite,
  input  logic                                          dataGrant,
  input  cpuTypesPkg::ramStateT                         ramstate,
  output logic                                          busy,
  output logic                                          ramREN,
  output logic                                          ramWEN,
  output cpuTypesPkg::addrT                             ramaddr,
  output cpuTypesPkg::wordT                             ramstore,
  output logic              [cpuTypesPkg::CPUS-1:0]     dwait,
  output logic              [cpuTypesPkg::CPUS-1:0]     ccwait,
  output logic              [cpuTypesPkg::CPUS-1:0]     ccinv,
  output cpuTypesPkg::addrT [cpuTypesPkg::CPUS-1:0]     ccsnoopaddr,
  output logic                                          dataDone
);

  typedef enum logic [2:0] {
    IDLE,
    SNOOP,
    LOAD,
    STORE,
    FORWARD
  } ccStateT;

  ccStateT state;
  ccStateT nextState;

  // core being served, latched when leaving IDLE
  logic owner;
  // the core that gets snooped
  logic other;
  logic ramDone;

  assign other   = ~owner;
  assign ramDone = (ramstate == cpuTypesPkg::ACCESS);
  assign busy    = (state != IDLE);

  // each core is only ever snooped on the other core's address
  assign ccsnoopaddr[0] = daddr[1];
  assign ccsnoopaddr[1] = daddr[0];

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= IDLE;
      owner <= 1'b0;
    end else begin
      state <= nextState;
      if (state == IDLE && nextState != IDLE) begin
        owner <= dataGrant;
      end
    end
  end

  always_comb begin
    nextState = state;
    ramREN    = 1'b0;
    ramWEN    = 1'b0;
    ramaddr   = daddr[owner];
    ramstore  = dstore[owner];
    dwait     = '1;
    ccwait    = '0;
    ccinv     = '0;
    dataDone  = 1'b0;

    case (state)
      IDLE: begin
        // ram port left idle here, so the latency count starts clean
        if (dWEN[dataGrant]) begin
          nextState = STORE;
        end else if (dREN[dataGrant]) begin
          nextState = SNOOP;
        end
      end

      SNOOP: begin
        // other cache answers ccwrite in this same cycle
        ccwait[other] = 1'b1;
        // exclusive read kills the other copy
        ccinv[other]  = ccwrite[owner];
        if (ccwrite[other]) begin
          nextState = FORWARD;
        end else begin
          nextState = LOAD;
        end
      end

      LOAD: begin
        ramREN = 1'b1;
        if (ramDone) begin
          dwait[owner] = 1'b0;
          dataDone     = 1'b1;
          nextState    = IDLE;
        end
      end

      STORE: begin
        ramWEN = 1'b1;
        if (ramDone) begin
          dwait[owner] = 1'b0;
          dataDone     = 1'b1;
          nextState    = IDLE;
        end
      end

      FORWARD: begin
        // dirty word goes to ram, requester picks it up off ramload
        ramWEN        = 1'b1;
        ramstore      = dstore[other];
        // snooped core holds its word until the write lands
        ccwait[other] = ~ramDone;
        if (ramDone) begin
          dwait[owner] = 1'b0;
          dataDone     = 1'b1;
          nextState    = IDLE;
        end
      end

      default: begin
        nextState = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/ramModel.sv
`timescale 1ns/1ps
`default_nettype none

module ramModel #(
  parameter int LATENCY   = 2,
  parameter int RAM_WORDS = 256
) (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  ramREN,
  input  logic                  ramWEN,
  input  cpuTypesPkg::addrT     ramaddr,
  input  cpuTypesPkg::wordT     ramstore,
  output cpuTypesPkg::wordT     ramload,
  output cpuTypesPkg::ramStateT ramstate
);

  localparam int CW = $clog2(LATENCY + 1);
  localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  cpuTypesPkg::wordT mem [RAM_WORDS];

  // cycles the current request has already been held
  logic [CW-1:0] count;
  logic [CW-1:0] heldCount;
  // last cycle's request, to spot a change
  logic          prevREN;
  logic          prevWEN;
  logic [29:0]   prevIndex;
  logic          active;
  logic          sameReq;
  logic          inRange;
  logic [AW-1:0] idx;

  assign active  = ramREN | ramWEN;
  assign sameReq = (prevREN == ramREN) && (prevWEN == ramWEN)
                && (prevIndex == ramaddr[31:2]);
  // any change restarts the count
  assign heldCount = sameReq ? count : '0;
  assign inRange   = {2'b00, ramaddr[31:2]} < 32'(RAM_WORDS);
  assign idx       = ramaddr[AW+1:2];

  always_comb begin
    if (!active) begin
      ramstate = cpuTypesPkg::FREE;
    end else if (!inRange) begin
      ramstate = cpuTypesPkg::ERROR;
    end else if (heldCount == CW'(LATENCY - 1)) begin
      ramstate = cpuTypesPkg::ACCESS;
    end else begin
      ramstate = cpuTypesPkg::BUSY;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      prevREN   <= 1'b0;
      prevWEN   <= 1'b0;
      prevIndex <= '0;
      count     <= '0;
    end else begin
      prevREN   <= ramREN;
      prevWEN   <= ramWEN;
      prevIndex <= ramaddr[31:2];
      // held request after ACCESS starts a fresh latency period
      if (ramstate == cpuTypesPkg::BUSY) begin
        count <= heldCount + 1'b1;
      end else begin
        count <= '0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (ramWEN && ramstate == cpuTypesPkg::ACCESS) begin
      mem[idx] <= ramstore;
    end
  end

  // write-first read port, so a forwarded word is visible on ramload
  always_comb begin
    if (!inRange) begin
      ramload = '0;
    end else if (ramWEN) begin
      ramload = ramstore;
    end else begin
      ramload = mem[idx];
    end
  end

endmodule

`default_nettype wire

// File: rtl/memoryControl.sv
`timescale 1ns/1ps
`default_nettype none

module memoryControl (
  input  logic                                      CLK,
  input  logic                                      reset,
  input  logic              [cpuTypesPkg::CPUS-1:0] iREN,
  input  cpuTypesPkg::addrT [cpuTypesPkg::CPUS-1:0] iaddr,
  output cpuTypesPkg::wordT [cpuTypesPkg::CPUS-1:0] iload,
  output logic              [cpuTypesPkg::CPUS-1:0] iwait,
  input  logic              [cpuTypesPkg::CPUS-1:0] dREN,
  input  logic              [cpuTypesPkg::CPUS-1:0] dWEN,
  input  cpuTypesPkg::addrT [cpuTypesPkg::CPUS-1:0] daddr,
  input  cpuTypesPkg::wordT [cpuTypesPkg::CPUS-1:0] dstore,
  output cpuTypesPkg::wordT [cpuTypesPkg::CPUS-1:0] dload,
  output logic              [cpuTypesPkg::CPUS-1:0] dwait,
  input  logic              [cpuTypesPkg::CPUS-1:0] ccwrite,
  output logic              [cpuTypesPkg::CPUS-1:0] ccwait,
  output logic              [cpuTypesPkg::CPUS-1:0] ccinv,
  output cpuTypesPkg::addrT [cpuTypesPkg::CPUS-1:0] ccsnoopaddr,
  output logic                                      ramREN,
  output logic                                      ramWEN,
  output cpuTypesPkg::addrT                         ramaddr,
  output cpuTypesPkg::wordT                         ramstore,
  input  cpuTypesPkg::wordT                         ramload,
  input  cpuTypesPkg::ramStateT                     ramstate
);

  logic              iGrant;
  logic              iDone;
  logic              dataGrant;
  logic              dataDone;
  logic              ccBusy;
  logic              ccRamREN;
  logic              ccRamWEN;
  cpuTypesPkg::addrT ccRamaddr;
  // data side owns the ram port
  logic              dataOwn;

  busArbiter dataArb (
    .CLK     (CLK),
    .reset   (reset),
    .request (dREN | dWEN),
    .done    (dataDone),
    .grant   (dataGrant)
  );

  busArbiter instrArb (
    .CLK     (CLK),
    .reset   (reset),
    .request (iREN),
    .done    (iDone),
    .grant   (iGrant)
  );

  coherenceController ccCtrl (
    .CLK         (CLK),
    .reset       (reset),
    .dREN        (dREN),
    .dWEN        (dWEN),
    .daddr       (daddr),
    .dstore      (dstore),
    .ccwrite     (ccwrite),
    .dataGrant   (dataGrant),
    .ramstate    (ramstate),
    .busy        (ccBusy),
    .ramREN      (ccRamREN),
    .ramWEN      (ccRamWEN),
    .ramaddr     (ccRamaddr),
    .ramstore    (ramstore),
    .dwait       (dwait),
    .ccwait      (ccwait),
    .ccinv       (ccinv),
    .ccsnoopaddr (ccsnoopaddr),
    .dataDone    (dataDone)
  );

  // pending data traffic blocks fetches, even before the FSM leaves IDLE
  assign dataOwn = ccBusy | (|(dREN | dWEN));

  // fetches are read only
  assign ramREN  = dataOwn ? ccRamREN : iREN[iGrant];
  assign ramWEN  = dataOwn & ccRamWEN;
  assign ramaddr = dataOwn ? ccRamaddr : iaddr[iGrant];

  assign iDone = ~dataOwn & iREN[iGrant] & (ramstate == cpuTypesPkg::ACCESS);

  always_comb begin
    iwait = '1;
    // only the granted fetch sees its wait drop
    if (iDone) begin
      iwait[iGrant] = 1'b0;
    end
  end

  // load data valid only while the matching wait is low
  assign dload = {cpuTypesPkg::CPUS{ramload}};
  assign iload = {cpuTypesPkg::CPUS{ramload}};

endmodule

`default_nettype wire

// File: rtl/memorySubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memorySubsystem #(
  parameter int LATENCY   = 2,
  parameter int RAM_WORDS = 256
) (
  input  logic                                      CLK,
  input  logic                                      reset,
  input  logic              [cpuTypesPkg::CPUS-1:0] iREN,
  input  cpuTypesPkg::addrT [cpuTypesPkg::CPUS-1:0] iaddr,
  output cpuTypesPkg::wordT [cpuTypesPkg::CPUS-1:0] iload,
  output logic              [cpuTypesPkg::CPUS-1:0] iwait,
  input  logic              [cpuTypesPkg::CPUS-1:0] dREN,
  input  logic              [cpuTypesPkg::CPUS-1:0] dWEN,
  input  cpuTypesPkg::addrT [cpuTypesPkg::CPUS-1:0] daddr,
  input  cpuTypesPkg::wordT [cpuTypesPkg::CPUS-1:0] dstore,
  output cpuTypesPkg::wordT [cpuTypesPkg::CPUS-1:0] dload,
  output logic              [cpuTypesPkg::CPUS-1:0] dwait,
  input  logic              [cpuTypesPkg::CPUS-1:0] ccwrite,
  output logic              [cpuTypesPkg::CPUS-1:0] ccwait,
  output logic              [cpuTypesPkg::CPUS-1:0] ccinv,
  output cpuTypesPkg::addrT [cpuTypesPkg::CPUS-1:0] ccsnoopaddr
);

  // single ram port between controller and ram
  logic                  ramREN;
  logic                  ramWEN;
  cpuTypesPkg::addrT     ramaddr;
  cpuTypesPkg::wordT     ramstore;
  cpuTypesPkg::wordT     ramload;
  cpuTypesPkg::ramStateT ramstate;

  memoryControl memCtrl (
    .CLK         (CLK),
    .reset       (reset),
    .iREN        (iREN),
    .iaddr       (iaddr),
    .iload       (iload),
    .iwait       (iwait),
    .dREN        (dREN),
    .dWEN        (dWEN),
    .daddr       (daddr),
    .dstore      (dstore),
    .dload       (dload),
    .dwait       (dwait),
    .ccwrite     (ccwrite),
    .ccwait      (ccwait),
    .ccinv       (ccinv),
    .ccsnoopaddr (ccsnoopaddr),
    .ramREN      (ramREN),
    .ramWEN      (ramWEN),
    .ramaddr     (ramaddr),
    .ramstore    (ramstore),
    .ramload     (ramload),
    .ramstate    (ramstate)
  );

  ramModel #(
    .LATENCY   (LATENCY),
    .RAM_WORDS (RAM_WORDS)
  ) ram (
    .CLK      (CLK),
    .reset    (reset),
    .ramREN   (ramREN),
    .ramWEN   (ramWEN),
    .ramaddr  (ramaddr),
    .ramstore (ramstore),
    .ramload  (ramload),
    .ramstate (ramstate)
  );

endmodule

`default_nettype wire

// File: tb/memorySubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memorySubsystemTb;

  localparam int RANDOM_OPS = 200;
  // forwarded read, setup edge through release edge, with margin
  localparam int OP_CYCLES = 8;
  localparam int TIMEOUT_CYCLES = 20 * RANDOM_OPS * OP_CYCLES;

  logic                         CLK;
  logic                         reset;
  logic              [1:0]      iREN;
  cpuTypesPkg::addrT [1:0]      iaddr;
  cpuTypesPkg::wordT [1:0]      iload;
  logic              [1:0]      iwait;
  logic              [1:0]      dREN;
  logic              [1:0]      dWEN;
  cpuTypesPkg::addrT [1:0]      daddr;
  cpuTypesPkg::wordT [1:0]      dstore;
  cpuTypesPkg::wordT [1:0]      dload;
  logic              [1:0]      dwait;
  logic              [1:0]      ccwrite;
  logic              [1:0]      ccwait;
  logic              [1:0]      ccinv;
  cpuTypesPkg::addrT [1:0]      ccsnoopaddr;

  // requester side of each core
  cpuTypesPkg::wordT [1:0]      storeData;
  logic              [1:0]      exclusive;
  // cache models keep the words held modified and a latched snoop answer
  logic [15:0]                  modValid [2];
  logic [31:0]                  modWord [2][16];
  logic [1:0]                   holding;
  logic [31:0]                  heldWord [2];
  logic [1:0]                   dirtyReq;
  logic [3:0]                   dirtyIdx;
  logic [31:0]                  dirtyWord;
  cpuTypesPkg::addrT            snoopAddr [2];
  cpuTypesPkg::addrT            invAddr [2];
  int                           invCount [2];
  // ram contents as seen through the forwarding rule
  logic [31:0]                  expMem [16];
  int                           doneOrder [$];
  int                           errors;
  int                           propertyErrors;
  int                           testsPassed;
  int                           testsFailed;
  int                           cycles;

  memorySubsystem u_dut (.*);

  always #4 CLK = ~CLK;

  // snooped core answers in the same cycle, then holds the word through ACCESS
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      if (holding[c]) begin
        ccwrite[c] = 1'b1;
        dstore[c]  = heldWord[c];
      end else if (ccwait[c]) begin
        ccwrite[c] = modValid[c][ccsnoopaddr[c][5:2]];
        dstore[c]  = modValid[c][ccsnoopaddr[c][5:2]] ? modWord[c][ccsnoopaddr[c][5:2]]
                                                      : storeData[c];
      end else begin
        ccwrite[c] = exclusive[c];
        dstore[c]  = storeData[c];
      end
    end
  end

  always @(posedge CLK) begin
    if (reset) begin
      holding     <= 2'b00;
      modValid[0] <= '0;
      modValid[1] <= '0;
      invCount[0] <= 0;
      invCount[1] <= 0;
      snoopAddr[0] <= '1;
      snoopAddr[1] <= '1;
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (ccwait[c] && !holding[c] && modValid[c][ccsnoopaddr[c][5:2]]) begin
          // word leaves the cache, ram gets it on the forward
          holding[c]  <= 1'b1;
          heldWord[c] <= modWord[c][ccsnoopaddr[c][5:2]];
          modValid[c][ccsnoopaddr[c][5:2]] <= 1'b0;
        end else if (!ccwait[c]) begin
          holding[c] <= 1'b0;
        end
        if (ccwait[c]) begin
          snoopAddr[c] <= ccsnoopaddr[c];
        end
        if (ccinv[c]) begin
          modValid[c][ccsnoopaddr[c][5:2]] <= 1'b0;
          invCount[c] <= invCount[c] + 1;
          invAddr[c]  <= ccsnoopaddr[c];
        end
        if (dirtyReq[c]) begin
          modValid[c][dirtyIdx] <= 1'b1;
          modWord[c][dirtyIdx]  <= dirtyWord;
        end
      end
    end
  end

  // nothing pending means a quiet bus
  assert property (@(posedge CLK) disable iff (reset)
    (iREN == 2'b00 && dREN == 2'b00 && dWEN == 2'b00)
      |-> (iwait == 2'b11 && dwait == 2'b11 && ccwait == 2'b00 && ccinv == 2'b00))
  else begin
    $display("error idle bus: expected waits 11 11 and no snoop, actual %b %b ccwait %b ccinv %b",
             $sampled(iwait), $sampled(dwait), $sampled(ccwait), $sampled(ccinv));
    propertyErrors++;
  end

  // one ram port, so one finished transfer per cycle
  assert property (@(posedge CLK) disable iff (reset) $countones({~iwait, ~dwait}) <= 1)
  else begin
    $display("arbitration: more than one wait low in one cycle");
    propertyErrors++;
  end

  // data traffic holds off every fetch
  assert property (@(posedge CLK) disable iff (reset) (dREN | dWEN) != 2'b00 |-> iwait == 2'b11)
  else begin
    $display("error data priority: expected iwait 11, actual %b", $sampled(iwait));
    propertyErrors++;
  end

  assert property (@(posedge CLK) disable iff (reset) ccinv != 2'b00 |=> ccinv == 2'b00)
  else begin
    $display("exclusive invalidate: ccinv stayed high for more than one cycle");
    propertyErrors++;
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: a request was still waiting after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] wordAddr(input logic [3:0] idx);
    return {26'd0, idx, 2'b00};
  endfunction

  function automatic logic [31:0] fillWord(input logic [3:0] idx);
    return (wordAddr(idx) * 32'h9E3779B1) ^ 32'h00C0FFEE;
  endfunction

  // modified copy in the other cache wins over ram
  function automatic logic [31:0] readExpect(input logic core, input logic [3:0] idx);
    if (modValid[~core][idx]) begin
      return modWord[~core][idx];
    end
    return expMem[idx];
  endfunction

  task automatic checkWord(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected)
    else begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic finishTest(input string name, input int mark);
    if (errors + propertyErrors == mark) begin
      $display("test %s: pass", name);
      testsPassed++;
    end else begin
      $display("test %s: fail", name);
      testsFailed++;
    end
  endtask

  task automatic makeDirty(input logic core, input logic [3:0] idx, input logic [31:0] word);
    @(negedge CLK);
    dirtyReq[core] = 1'b1;
    dirtyIdx       = idx;
    dirtyWord      = word;
    @(negedge CLK);
    dirtyReq[core] = 1'b0;
  endtask

  task automatic storeTracked(input logic core, input logic [3:0] idx, input logic [31:0] word);
    expMem[idx] = word;
    @(negedge CLK);
    dWEN[core]      = 1'b1;
    daddr[core]     = wordAddr(idx);
    storeData[core] = word;
    do @(posedge CLK); while (dwait[core]);
    @(negedge CLK);
    dWEN[core] = 1'b0;
  endtask

  task automatic loadAndCheck(input string name, input logic core, input logic [3:0] idx,
                              input logic excl);
    logic [31:0] expected;
    logic [31:0] got;
    expected    = readExpect(core, idx);
    expMem[idx] = expected;
    @(negedge CLK);
    dREN[core]      = 1'b1;
    daddr[core]     = wordAddr(idx);
    exclusive[core] = excl;
    do @(posedge CLK); while (dwait[core]);
    got = dload[core];
    @(negedge CLK);
    dREN[core]      = 1'b0;
    exclusive[core] = 1'b0;
    checkWord(name, expected, got);
  endtask

  // fetches skip the snoop and read ram directly
  task automatic fetchAndCheck(input string name, input logic core, input logic [3:0] idx);
    logic [31:0] got;
    @(negedge CLK);
    iREN[core]  = 1'b1;
    iaddr[core] = wordAddr(idx);
    do @(posedge CLK); while (iwait[core]);
    got = iload[core];
    doneOrder.push_back(int'(core));
    @(negedge CLK);
    iREN[core] = 1'b0;
    checkWord(name, expMem[idx], got);
  endtask

  task automatic fetchSeries(input logic core, input int count);
    for (int k = 0; k < count; k++) begin
      fetchAndCheck("arbitration", core, 4'(k + 4 * int'(core)));
    end
  endtask

  initial begin
    int          mark;
    int          invBefore;
    int          expectedCore;
    logic        core;
    logic [3:0]  idx;
    CLK       = 1'b0;
    reset     = 1'b1;
    iREN      = '0;
    iaddr     = '0;
    dREN      = '0;
    dWEN      = '0;
    daddr     = '0;
    storeData = '0;
    exclusive = '0;
    dirtyReq  = '0;
    dirtyIdx  = '0;
    dirtyWord = '0;
    errors         = 0;
    propertyErrors = 0;
    testsPassed    = 0;
    testsFailed    = 0;
    cycles         = 0;
    void'($urandom(32'h682));
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    reset = 1'b0;

    mark = errors + propertyErrors;
    repeat (4) begin
      @(posedge CLK);
      assert (iwait == 2'b11 && dwait == 2'b11 && ccwait == 2'b00 && ccinv == 2'b00)
      else begin
        $display("error reset: expected waits 11 11 ccwait 00 ccinv 00, actual %b %b %b %b",
                 iwait, dwait, ccwait, ccinv);
        errors++;
      end
    end
    finishTest("reset", mark);

    // known contents everywhere before any read
    for (int i = 0; i < 16; i++) begin
      storeTracked(1'(i), 4'(i), fillWord(4'(i)));
    end

    mark = errors + propertyErrors;
    storeTracked(1'b0, 4'd3, 32'h1234ABCD);
    loadAndCheck("store then load", 1'b1, 4'd3, 1'b0);
    assert (snoopAddr[0] == wordAddr(4'd3))
    else begin
      $display("error store then load: expected snoop address %h, actual %h",
               wordAddr(4'd3), snoopAddr[0]);
      errors++;
    end
    finishTest("store then load", mark);

    mark = errors + propertyErrors;
    doneOrder.delete();
    fork
      begin
        loadAndCheck("arbitration", 1'b0, 4'd9, 1'b0);
        doneOrder.push_back(2);
      end
      fetchSeries(1'b0, 3);
      fetchSeries(1'b1, 3);
    join
    // data first, then fetches alternate starting at core 0
    for (int k = 0; k < 7; k++) begin
      expectedCore = (k == 0) ? 2 : (k - 1) % 2;
      assert (k < doneOrder.size() && doneOrder[k] == expectedCore)
      else begin
        $display("error arbitration: expected completion %0d from %0d, actual %0d",
                 k, expectedCore, (k < doneOrder.size()) ? doneOrder[k] : -1);
        errors++;
      end
    end
    finishTest("arbitration", mark);

    mark = errors + propertyErrors;
    makeDirty(1'b1, 4'd7, 32'h0BADF00D);
    loadAndCheck("dirty forward", 1'b0, 4'd7, 1'b0);
    // core 1 is clean now, so this one comes out of ram
    loadAndCheck("dirty forward", 1'b0, 4'd7, 1'b0);
    finishTest("dirty forward", mark);

    mark = errors + propertyErrors;
    invBefore = invCount[0];
    loadAndCheck("exclusive invalidate", 1'b1, 4'd5, 1'b1);
    checkWord("exclusive invalidate", 32'(invBefore + 1), 32'(invCount[0]));
    checkWord("exclusive invalidate", wordAddr(4'd5), invAddr[0]);
    finishTest("exclusive invalidate", mark);

    mark = errors + propertyErrors;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      core = 1'($urandom_range(1, 0));
      idx  = 4'($urandom_range(15, 0));
      case ($urandom_range(3, 0))
        0: loadAndCheck("random mix", core, idx, 1'($urandom_range(1, 0)));
        1: storeTracked(core, idx, $urandom);
        2: fetchAndCheck("random mix", core, idx);
        default: begin
          // only one core may hold a word modified
          if (!modValid[~core][idx]) begin
            makeDirty(core, idx, $urandom);
          end
        end
      endcase
    end
    finishTest("random mix", mark);

    $display("tests passed %0d, tests failed %0d, errors %0d", testsPassed, testsFailed,
             errors + propertyErrors);
    if (errors + propertyErrors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
rtl/cpuTypesPkg.sv
rtl/busArbiter.sv
rtl/coherenceController.sv
rtl/ramModel.sv
rtl/memoryControl.sv
rtl/memorySubsystem.sv
tb/memorySubsystemTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
  --top-module memorySubsystemTb -o memorySubsystemSim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/memorySubsystemSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
